/* design/cpuPkg.sv */
package cpuPkg;

    // architectural register file.
    localparam int RegNum   = 32;
    localparam int RegNameW = 5;

    // datapath widths.
    localparam int DataW = 32;
    localparam int AddrW = 32;
    localparam int ImmW  = 32;
    localparam int OpW   = 6;

    // reorder buffer geometry.
    localparam int RobDepth = 8;
    localparam int RobPtrW  = $clog2(RobDepth);
    localparam int RobCntW  = $clog2(RobDepth + 1);

    // tag zero means the value is ready, live tags are slot index plus one.
    localparam int NickW = 4;

    // stores have no destination, so they never rename.
    localparam logic [OpW-1:0] OpSb = 6'd27;
    localparam logic [OpW-1:0] OpSh = 6'd28;
    localparam logic [OpW-1:0] OpSw = 6'd29;

endpackage

/* design/reorderBuf.sv */
`timescale 1ns/1ps

module reorderBuf (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        rdy,
    input  logic                        flush,
    input  logic                        issueEn,
    input  logic [cpuPkg::RegNameW-1:0] rd,
    input  logic [cpuPkg::OpW-1:0]      op,
    input  logic                        wbEn,
    input  logic [cpuPkg::NickW-1:0]    wbNick,
    input  logic [cpuPkg::DataW-1:0]    wbData,
    output logic                        robFull,
    output logic                        allocEn,
    output logic [cpuPkg::NickW-1:0]    allocNick,
    output logic                        cmtEn,
    output logic [cpuPkg::RegNameW-1:0] cmtRd,
    output logic [cpuPkg::DataW-1:0]    cmtData,
    output logic [cpuPkg::NickW-1:0]    cmtNick,
    output logic                        cmtWrites
);

    logic [cpuPkg::RegNameW-1:0] slotRd     [cpuPkg::RobDepth];
    logic                        slotWrites [cpuPkg::RobDepth];
    logic [cpuPkg::DataW-1:0]    slotData   [cpuPkg::RobDepth];
    logic [cpuPkg::RobDepth-1:0] slotDone;

    logic [cpuPkg::RobPtrW-1:0] head;
    logic [cpuPkg::RobPtrW-1:0] tail;
    logic [cpuPkg::RobCntW-1:0] count;

    logic                       issueOk;
    logic                       hasDest;
    logic                       wbOk;
    logic                       popOk;
    logic [cpuPkg::RobPtrW-1:0] wbSlot;

    function automatic logic [cpuPkg::NickW-1:0] toNick(input logic [cpuPkg::RobPtrW-1:0] ptr);
        return cpuPkg::NickW'(ptr) + cpuPkg::NickW'(1);
    endfunction

    assign robFull = count == cpuPkg::RobCntW'(cpuPkg::RobDepth);
    assign issueOk = issueEn && !robFull && rdy && !flush;

    // x0 and stores still take a slot, just no register.
    assign hasDest = (rd != '0) && (op != cpuPkg::OpSb) && (op != cpuPkg::OpSh)
                     && (op != cpuPkg::OpSw);

    assign allocEn   = issueOk && hasDest;
    assign allocNick = toNick(tail);

    assign wbOk   = wbEn && rdy && !flush;
    assign wbSlot = cpuPkg::RobPtrW'(wbNick - cpuPkg::NickW'(1));
    assign popOk  = rdy && !flush && (count != '0) && slotDone[head];

    // pointers wrap on their own, depth is a power of two.
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            head     <= '0;
            tail     <= '0;
            count    <= '0;
            slotDone <= '0;
            cmtEn    <= 1'b0;
        end else if (rdy) begin
            cmtEn <= popOk;
            if (issueOk) begin
                tail           <= tail + cpuPkg::RobPtrW'(1);
                slotDone[tail] <= 1'b0;
            end
            if (wbOk) begin
                slotDone[wbSlot] <= 1'b1;
            end
            if (popOk) begin
                head           <= head + cpuPkg::RobPtrW'(1);
                slotDone[head] <= 1'b0;
            end
            case ({issueOk, popOk})
                2'b10:   count <= count + cpuPkg::RobCntW'(1);
                2'b01:   count <= count - cpuPkg::RobCntW'(1);
                default: count <= count;
            endcase
        end else begin
            cmtEn <= 1'b0; // stalled, no commit pulse.
        end
    end

    always_ff @(posedge clk) begin
        if (issueOk) begin
            slotRd[tail]     <= rd;
            slotWrites[tail] <= hasDest;
        end
        if (wbOk) begin
            slotData[wbSlot] <= wbData;
        end
        // head is popped into the commit registers.
        if (popOk) begin
            cmtRd     <= slotRd[head];
            cmtData   <= slotData[head];
            cmtNick   <= toNick(head);
            cmtWrites <= slotWrites[head];
        end
    end

endmodule

/* design/regFile.sv */
`timescale 1ns/1ps

module regFile (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        rdy,
    input  logic                        flush,
    input  logic                        issueEn,
    input  logic [cpuPkg::RegNameW-1:0] rs1,
    input  logic [cpuPkg::RegNameW-1:0] rs2,
    input  logic [cpuPkg::RegNameW-1:0] rd,
    input  logic [cpuPkg::OpW-1:0]      op,
    input  logic [cpuPkg::AddrW-1:0]    pc,
    input  logic [cpuPkg::ImmW-1:0]     imm,
    input  logic                        predTaken,
    input  logic                        allocEn,
    input  logic [cpuPkg::NickW-1:0]    allocNick,
    input  logic                        cmtEn,
    input  logic                        cmtWrites,
    input  logic [cpuPkg::RegNameW-1:0] cmtRd,
    input  logic [cpuPkg::DataW-1:0]    cmtData,
    input  logic [cpuPkg::NickW-1:0]    cmtNick,
    output logic                        dpEn,
    output logic [cpuPkg::DataW-1:0]    dpRs1Data,
    output logic [cpuPkg::DataW-1:0]    dpRs2Data,
    output logic [cpuPkg::NickW-1:0]    dpRs1Nick,
    output logic [cpuPkg::NickW-1:0]    dpRs2Nick,
    output logic [cpuPkg::RegNameW-1:0] dpRd,
    output logic [cpuPkg::OpW-1:0]      dpOp,
    output logic [cpuPkg::AddrW-1:0]    dpPc,
    output logic [cpuPkg::ImmW-1:0]     dpImm,
    output logic                        dpPredTaken
);

    logic [cpuPkg::DataW-1:0] dataArr [cpuPkg::RegNum];
    logic [cpuPkg::NickW-1:0] nickArr [cpuPkg::RegNum];

    logic cmtWrite;
    logic dpLoad;

    assign cmtWrite = cmtEn && cmtWrites;
    assign dpLoad   = rdy && issueEn;

    // source read with the same-cycle commit folded in.
    function automatic logic [cpuPkg::DataW-1:0] readData(input logic [cpuPkg::RegNameW-1:0] rs);
        if (rs == '0) begin
            return '0;
        end
        if (cmtWrite && cmtRd == rs) begin
            return cmtData;
        end
        return dataArr[rs];
    endfunction

    function automatic logic [cpuPkg::NickW-1:0] readNick(input logic [cpuPkg::RegNameW-1:0] rs);
        if (rs == '0) begin
            return '0;
        end
        if (cmtWrite && cmtRd == rs && nickArr[rs] == cmtNick) begin
            return '0; // owner commits this cycle.
        end
        return nickArr[rs];
    endfunction

    // an in-flight commit always lands, even on flush or stall.
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < cpuPkg::RegNum; i++) begin
                dataArr[i] <= '0;
                nickArr[i] <= '0;
            end
        end else begin
            if (cmtWrite) begin
                dataArr[cmtRd] <= cmtData;
            end
            if (flush) begin
                for (int i = 0; i < cpuPkg::RegNum; i++) begin
                    nickArr[i] <= '0;
                end
            end else begin
                if (cmtWrite && nickArr[cmtRd] == cmtNick) begin
                    nickArr[cmtRd] <= '0;
                end
                if (allocEn) begin
                    nickArr[rd] <= allocNick; // rename wins over the clear.
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            dpEn <= 1'b0;
        end else begin
            dpEn <= dpLoad;
        end
    end

    always_ff @(posedge clk) begin
        if (dpLoad) begin
            dpRs1Data   <= readData(rs1);
            dpRs2Data   <= readData(rs2);
            dpRs1Nick   <= readNick(rs1);
            dpRs2Nick   <= readNick(rs2);
            dpRd        <= rd;
            dpOp        <= op;
            dpPc        <= pc;
            dpImm       <= imm;
            dpPredTaken <= predTaken;
        end
    end

endmodule

/* design/renameCore.sv */
`timescale 1ns/1ps

module renameCore (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        issueEn,
    input  logic [cpuPkg::RegNameW-1:0] rs1,
    input  logic [cpuPkg::RegNameW-1:0] rs2,
    input  logic [cpuPkg::RegNameW-1:0] rd,
    input  logic [cpuPkg::OpW-1:0]      op,
    input  logic [cpuPkg::AddrW-1:0]    pc,
    input  logic [cpuPkg::ImmW-1:0]     imm,
    input  logic                        predTaken,
    input  logic                        wbEn,
    input  logic [cpuPkg::NickW-1:0]    wbNick,
    input  logic [cpuPkg::DataW-1:0]    wbData,
    input  logic                        flush,
    input  logic                        rdy,
    output logic                        robFull,
    output logic                        dpEn,
    output logic [cpuPkg::DataW-1:0]    dpRs1Data,
    output logic [cpuPkg::DataW-1:0]    dpRs2Data,
    output logic [cpuPkg::NickW-1:0]    dpRs1Nick,
    output logic [cpuPkg::NickW-1:0]    dpRs2Nick,
    output logic [cpuPkg::RegNameW-1:0] dpRd,
    output logic [cpuPkg::OpW-1:0]      dpOp,
    output logic [cpuPkg::AddrW-1:0]    dpPc,
    output logic [cpuPkg::ImmW-1:0]     dpImm,
    output logic                        dpPredTaken,
    output logic                        cmtEn,
    output logic [cpuPkg::RegNameW-1:0] cmtRd,
    output logic [cpuPkg::DataW-1:0]    cmtData,
    output logic [cpuPkg::NickW-1:0]    cmtNick
);

    logic                     allocEn;
    logic [cpuPkg::NickW-1:0] allocNick;
    logic                     cmtWrites; // false for stores and x0.

    reorderBuf robI (
        .clk       (clk),
        .rst       (rst),
        .rdy       (rdy),
        .flush     (flush),
        .issueEn   (issueEn),
        .rd        (rd),
        .op        (op),
        .wbEn      (wbEn),
        .wbNick    (wbNick),
        .wbData    (wbData),
        .robFull   (robFull),
        .allocEn   (allocEn),
        .allocNick (allocNick),
        .cmtEn     (cmtEn),
        .cmtRd     (cmtRd),
        .cmtData   (cmtData),
        .cmtNick   (cmtNick),
        .cmtWrites (cmtWrites)
    );

    regFile regFileI (
        .clk         (clk),
        .rst         (rst),
        .rdy         (rdy),
        .flush       (flush),
        .issueEn     (issueEn),
        .rs1         (rs1),
        .rs2         (rs2),
        .rd          (rd),
        .op          (op),
        .pc          (pc),
        .imm         (imm),
        .predTaken   (predTaken),
        .allocEn     (allocEn),
        .allocNick   (allocNick),
        .cmtEn       (cmtEn),
        .cmtWrites   (cmtWrites),
        .cmtRd       (cmtRd),
        .cmtData     (cmtData),
        .cmtNick     (cmtNick),
        .dpEn        (dpEn),
        .dpRs1Data   (dpRs1Data),
        .dpRs2Data   (dpRs2Data),
        .dpRs1Nick   (dpRs1Nick),
        .dpRs2Nick   (dpRs2Nick),
        .dpRd        (dpRd),
        .dpOp        (dpOp),
        .dpPc        (dpPc),
        .dpImm       (dpImm),
        .dpPredTaken (dpPredTaken)
    );

endmodule

/* sim/renameCore_properties.sv */
`timescale 1ns/1ps

module renameCore_properties (
    input logic                     clk,
    input logic                     rst,
    input logic                     flush,
    input logic                     rdy,
    input logic                     issueEn,
    input logic                     robFull,
    input logic                     dpEn,
    input logic                     cmtEn,
    input logic [cpuPkg::NickW-1:0] cmtNick
);

    // no dispatch right after a flush or a stalled cycle.
    dpQuiet: assert property (@(posedge clk) disable iff (rst)
        ($past(flush) || !$past(rdy)) |-> !dpEn)
        else $error("dispatch seen after flush or stall");

    noIssueWhenFull: assert property (@(posedge clk) disable iff (rst)
        issueEn |-> !robFull)
        else $error("issue raised while reorder buffer full");

    // back-to-back commits carry consecutive tags.
    cmtNickLive: assert property (@(posedge clk) disable iff (rst)
        cmtEn |-> (cmtNick != '0) && (!$past(cmtEn)
            || cmtNick == cpuPkg::NickW'($past(cmtNick) % cpuPkg::RobDepth + 1)))
        else $error("commit with tag zero or out of allocation order");

endmodule

bind renameCore renameCore_properties propsI (
    .clk     (clk),
    .rst     (rst),
    .flush   (flush),
    .rdy     (rdy),
    .issueEn (issueEn),
    .robFull (robFull),
    .dpEn    (dpEn),
    .cmtEn   (cmtEn),
    .cmtNick (cmtNick)
);

/* sim/renameCore_tb.sv */
`timescale 1ns/1ps

module renameCore_tb;

    localparam string VecFile  = "sim/renameVectors.txt";
    localparam int    MaxLines = 64;
    localparam int    NumCols  = 21;
    localparam int    WaitMax  = 50;

    logic clk;
    logic rst;
    logic issueEn, predTaken, wbEn, flush, rdy;
    logic [cpuPkg::RegNameW-1:0] rs1, rs2, rd;
    logic [cpuPkg::OpW-1:0]      op;
    logic [cpuPkg::AddrW-1:0]    pc;
    logic [cpuPkg::ImmW-1:0]     imm;
    logic [cpuPkg::NickW-1:0]    wbNick;
    logic [cpuPkg::DataW-1:0]    wbData;
    logic robFull, dpEn, dpPredTaken, cmtEn;
    logic [cpuPkg::DataW-1:0]    dpRs1Data, dpRs2Data, cmtData;
    logic [cpuPkg::NickW-1:0]    dpRs1Nick, dpRs2Nick, cmtNick;
    logic [cpuPkg::RegNameW-1:0] dpRd, cmtRd;
    logic [cpuPkg::OpW-1:0]      dpOp;
    logic [cpuPkg::AddrW-1:0]    dpPc;
    logic [cpuPkg::ImmW-1:0]     dpImm;

    logic [31:0] vecs [MaxLines][NumCols];
    int          numLines;
    integer      seed;

    renameCore renameCore_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic checkVal(input string name, input logic [31:0] expv, input logic [31:0] actv);
        if (actv !== expv) begin
            $display("MISMATCH t=%0t %s expected %h actual %h", $time, name, expv, actv);
            $display("=== FAIL ===");
            $fatal(1);
        end
    endtask

    task automatic loadVectors();
        int          fd;
        string       line;
        logic [31:0] v [NumCols];
        fd = $fopen(VecFile, "r");
        if (fd == 0) begin
            $display("could not open the vector file %s", VecFile);
            $display("=== FAIL ===");
            $fatal(1);
        end
        numLines = 0;
        while (!$feof(fd) && numLines < MaxLines) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line[0] != "#") begin
                if ($sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9], v[10],
                        v[11], v[12], v[13], v[14], v[15], v[16], v[17], v[18], v[19],
                        v[20]) != NumCols) begin
                    $display("malformed vector line: %s", line);
                    $display("=== FAIL ===");
                    $fatal(1);
                end
                vecs[numLines] = v;
                numLines++;
            end
        end
        $fclose(fd);
    endtask

    task automatic waitNotFull();
        int n;
        n = 0;
        while (robFull !== 1'b0) begin
            @(posedge clk);
            n++;
            if (n > WaitMax) begin
                $display("reorder buffer still full after reset");
                $display("=== FAIL ===");
                $fatal(1);
            end
        end
    endtask

    // outputs one edge after line k was driven.
    task automatic checkLine(input int k);
        checkVal("dpEn", vecs[k][10], 32'(dpEn));
        checkVal("cmtEn", vecs[k][15], 32'(cmtEn));
        checkVal("robFull", vecs[k][19], 32'(robFull));
        if (vecs[k][20][0]) begin
            checkVal("dpRs1Data", vecs[k][11], dpRs1Data);
            checkVal("dpRs2Data", vecs[k][12], dpRs2Data);
            checkVal("dpRs1Nick", vecs[k][13], 32'(dpRs1Nick));
            checkVal("dpRs2Nick", vecs[k][14], 32'(dpRs2Nick));
            checkVal("dpRd", vecs[k][3], 32'(dpRd)); // fields pass through.
            checkVal("dpOp", vecs[k][4], 32'(dpOp));
            checkVal("dpPc", 32'h1000 + 32'(k) * 4, dpPc);
            checkVal("dpImm", imm, dpImm);
            checkVal("dpPredTaken", 32'(k % 2), 32'(dpPredTaken));
        end
        if (vecs[k][20][1]) begin
            checkVal("cmtRd", vecs[k][16], 32'(cmtRd));
            checkVal("cmtData", vecs[k][17], cmtData);
            checkVal("cmtNick", vecs[k][18], 32'(cmtNick));
        end
    endtask

    task automatic driveLine(input int k);
        issueEn   = vecs[k][0][0];
        rs1       = vecs[k][1][4:0];
        rs2       = vecs[k][2][4:0];
        rd        = vecs[k][3][4:0];
        op        = vecs[k][4][5:0];
        pc        = 32'h1000 + 32'(k) * 4;
        imm       = $random(seed);
        predTaken = k[0];
        wbEn      = vecs[k][5][0];
        wbNick    = vecs[k][6][3:0];
        wbData    = vecs[k][7];
        flush     = vecs[k][8][0];
        rdy       = vecs[k][9][0];
    endtask

    initial begin
        seed = 32'h31a6_a9da;
        rst = 1'b1;
        issueEn = 1'b0;
        rs1 = '0;
        rs2 = '0;
        rd = '0;
        op = '0;
        pc = '0;
        imm = '0;
        predTaken = 1'b0;
        wbEn = 1'b0;
        wbNick = '0;
        wbData = '0;
        flush = 1'b0;
        rdy = 1'b1;
        loadVectors();
        repeat (8) @(posedge clk);
        #1 rst = 1'b0;
        waitNotFull();
        for (int k = 0; k < numLines; k++) begin
            @(posedge clk);
            #1;
            if (k > 0) begin
                checkLine(k - 1);
            end
            driveLine(k);
        end
        @(posedge clk);
        #1;
        checkLine(numLines - 1);
        $display("=== PASS ===");
        $finish;
    end

endmodule

/* build.f */
design/cpuPkg.sv
design/reorderBuf.sv
design/regFile.sv
design/renameCore.sv
sim/renameCore_properties.sv
sim/renameCore_tb.sv

/* Makefile */
SIM = obj_dir/VrenameCore_tb

all: run

$(SIM): build.f design/cpuPkg.sv design/reorderBuf.sv design/regFile.sv design/renameCore.sv \
        sim/renameCore_properties.sv sim/renameCore_tb.sv
	verilator --binary --timing --assert -f build.f --top-module renameCore_tb -o VrenameCore_tb

run: $(SIM) sim/renameVectors.txt
	-./$(SIM) > sim.log 2>&1
	cat sim.log
	grep -q "=== PASS ===" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

/* sim/renameVectors.txt */
# iss rs1 rs2 rd op wbEn wbNick wbData flush rdy | expected next cycle:
# dpEn rs1Data rs2Data rs1Nick rs2Nick cmtEn cmtRd cmtData cmtNick robFull mask
1 01 02 03 01 0 0 00 0 1  1 00 00 0 0 0 00 00 0 0 1
1 03 03 03 01 0 0 00 0 1  1 00 00 1 1 0 00 00 0 0 1
1 04 00 04 01 0 0 00 0 1  1 00 00 0 0 0 00 00 0 0 1
0 00 00 00 00 1 3 33 0 1  0 00 00 0 0 0 00 00 0 0 0
0 00 00 00 00 1 2 22 0 1  0 00 00 0 0 0 00 00 0 0 0
0 00 00 00 00 1 1 11 0 1  0 00 00 0 0 0 00 00 0 0 0
0 00 00 00 00 0 0 00 0 1  0 00 00 0 0 1 03 11 1 0 2
1 03 04 00 01 0 0 00 0 1  1 11 00 2 3 1 03 22 2 0 3
1 03 03 05 01 0 0 00 0 1  1 22 22 0 0 1 04 33 3 0 3
1 04 03 06 1d 1 4 44 0 1  1 33 22 0 0 0 00 00 0 0 1
1 00 06 00 01 0 0 00 0 1  1 00 00 0 0 1 00 44 4 0 3
1 00 05 07 01 0 0 00 0 1  1 00 00 0 5 0 00 00 0 0 1
1 00 00 08 01 0 0 00 0 1  1 00 00 0 0 0 00 00 0 0 1
1 00 00 09 01 0 0 00 0 1  1 00 00 0 0 0 00 00 0 0 1
1 00 00 0a 01 0 0 00 0 1  1 00 00 0 0 0 00 00 0 0 1
1 00 00 0b 01 0 0 00 0 1  1 00 00 0 0 0 00 00 0 1 1
0 00 00 00 00 1 5 55 0 0  0 00 00 0 0 0 00 00 0 1 0
0 00 00 00 00 0 0 00 0 1  0 00 00 0 0 0 00 00 0 1 0
0 00 00 00 00 0 0 00 1 1  0 00 00 0 0 0 00 00 0 0 0
1 03 07 08 01 0 0 00 0 1  1 22 00 0 0 0 00 00 0 0 1
1 08 04 00 01 0 0 00 0 1  1 00 33 1 0 0 00 00 0 0 1
0 00 00 00 00 0 0 00 0 1  0 00 00 0 0 0 00 00 0 0 0
